// ==== design/jvm_pkg.sv ====
package jvm_pkg;

    // queue sizing, also the credits a sender starts with
    localparam int LINK_DEPTH  = 4;
    localparam int STACK_DEPTH = 16;
    localparam int NUM_LOCALS  = 4;

    // depths are powers of two, pointers wrap on their own
    localparam int LINK_PTR_W = $clog2(LINK_DEPTH);
    localparam int LINK_CNT_W = $clog2(LINK_DEPTH + 1);
    localparam int STK_IDX_W  = $clog2(STACK_DEPTH);
    localparam int SP_W       = $clog2(STACK_DEPTH + 1);
    localparam int LOCAL_W    = $clog2(NUM_LOCALS);

    localparam logic [7:0] OP_NOP       = 8'h00;
    localparam logic [7:0] OP_ICONST_M1 = 8'h02;
    localparam logic [7:0] OP_ICONST_0  = 8'h03;
    localparam logic [7:0] OP_ICONST_1  = 8'h04;
    localparam logic [7:0] OP_ICONST_2  = 8'h05;
    localparam logic [7:0] OP_ICONST_3  = 8'h06;
    localparam logic [7:0] OP_ICONST_4  = 8'h07;
    localparam logic [7:0] OP_ICONST_5  = 8'h08;
    localparam logic [7:0] OP_BIPUSH    = 8'h10;
    localparam logic [7:0] OP_SIPUSH    = 8'h11;
    localparam logic [7:0] OP_ILOAD     = 8'h15;
    localparam logic [7:0] OP_ILOAD_0   = 8'h1a;
    localparam logic [7:0] OP_ILOAD_1   = 8'h1b;
    localparam logic [7:0] OP_ILOAD_2   = 8'h1c;
    localparam logic [7:0] OP_ILOAD_3   = 8'h1d;
    localparam logic [7:0] OP_ISTORE    = 8'h36;
    localparam logic [7:0] OP_ISTORE_0  = 8'h3b;
    localparam logic [7:0] OP_ISTORE_1  = 8'h3c;
    localparam logic [7:0] OP_ISTORE_2  = 8'h3d;
    localparam logic [7:0] OP_ISTORE_3  = 8'h3e;
    localparam logic [7:0] OP_POP       = 8'h57;
    localparam logic [7:0] OP_DUP       = 8'h59;
    localparam logic [7:0] OP_IADD      = 8'h60;
    localparam logic [7:0] OP_ISUB      = 8'h64;
    localparam logic [7:0] OP_IMUL      = 8'h68;
    localparam logic [7:0] OP_IDIV      = 8'h6c;
    localparam logic [7:0] OP_IREM      = 8'h70;
    localparam logic [7:0] OP_INEG      = 8'h74;
    localparam logic [7:0] OP_ISHL      = 8'h78;
    localparam logic [7:0] OP_ISHR      = 8'h7a;
    localparam logic [7:0] OP_IAND      = 8'h7e;
    localparam logic [7:0] OP_IOR       = 8'h80;
    localparam logic [7:0] OP_IXOR      = 8'h82;
    localparam logic [7:0] OP_IINC      = 8'h84;
    localparam logic [7:0] OP_IRETURN   = 8'hac;
    localparam logic [7:0] OP_RETURN    = 8'hb1;

    // codes come straight from opcode bits in the decoder
    typedef enum logic [3:0] {
        alu_add = 4'b0000,
        alu_sub = 4'b0001,
        alu_mul = 4'b0010,
        alu_div = 4'b0011,
        alu_rem = 4'b0100,
        alu_neg = 4'b0101,
        alu_or  = 4'b1000,
        alu_xor = 4'b1001,
        alu_shl = 4'b1100,
        alu_shr = 4'b1101,
        alu_and = 4'b1111
    } alu_op_e;

    typedef enum logic [3:0] {
        k_nop,
        k_push_const,
        k_load,
        k_store,
        k_iinc,
        k_pop,
        k_dup,
        k_alu,
        k_ireturn,
        k_return,
        k_illegal
    } instr_kind_e;

    typedef struct packed {
        instr_kind_e          kind;
        alu_op_e              alu_op;
        logic [1:0]           stack_args;
        logic                 stack_wb;
        logic [LOCAL_W-1:0]   local_idx;
        logic [31:0]          imm;
    } decoded_instr_t;

endpackage

// ==== design/credit_link.sv ====
`timescale 1ns/100ps

// one-way payload link, credits flow back from the receiver
interface credit_link #(
    parameter type payload_t = logic [7:0]
);
    logic     valid;
    payload_t data;
    // one pulse per entry the receiver frees
    logic     credit;

    modport sender (output valid, output data, input credit);
    modport receiver (input valid, input data, output credit);
endinterface

// ==== design/credit_fifo.sv ====
`timescale 1ns/100ps

module credit_fifo
    import jvm_pkg::*;
#(
    parameter type payload_t = logic [7:0]
) (
    input  logic         clk,
    input  logic         rst_n,
    credit_link.receiver up,
    credit_link.sender   down
);

    payload_t              mem [LINK_DEPTH];
    logic [LINK_PTR_W-1:0] wr_ptr;
    logic [LINK_PTR_W-1:0] rd_ptr;
    logic [LINK_CNT_W-1:0] count;
    logic [LINK_CNT_W-1:0] credits;
    logic                  fwd;

    // forward the head whenever the receiver has room for it
    assign fwd        = (count != '0) && (credits != '0);
    assign down.valid = fwd;
    assign down.data  = mem[rd_ptr];
    // each forwarded entry frees a slot upstream
    assign up.credit  = fwd;

    always_ff @(posedge clk) begin
        if (up.valid) begin
            mem[wr_ptr] <= up.data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= LINK_CNT_W'(LINK_DEPTH);
        end else begin
            if (up.valid) begin
                wr_ptr <= wr_ptr + LINK_PTR_W'(1);
            end
            if (fwd) begin
                rd_ptr <= rd_ptr + LINK_PTR_W'(1);
            end
            count   <= count + LINK_CNT_W'(up.valid) - LINK_CNT_W'(fwd);
            credits <= credits - LINK_CNT_W'(fwd) + LINK_CNT_W'(down.credit);
        end
    end

endmodule

// ==== design/bytecode_decoder.sv ====
`timescale 1ns/100ps

module bytecode_decoder
    import jvm_pkg::*;
(
    input  logic [7:0]     opcode,
    output logic [1:0]     arg_count,
    output decoded_instr_t base
);

    always_comb begin
        base      = '0;
        arg_count = 2'd0;
        case (opcode)
            OP_NOP: begin
                base.kind = k_nop;
            end
            OP_ICONST_M1, OP_ICONST_0, OP_ICONST_1, OP_ICONST_2,
            OP_ICONST_3, OP_ICONST_4, OP_ICONST_5: begin
                // opcode minus 3, so 0x02 wraps to -1
                base.kind     = k_push_const;
                base.stack_wb = 1'b1;
                base.imm      = 32'(opcode) - 32'd3;
            end
            OP_BIPUSH, OP_SIPUSH: begin
                // sipush is the odd one and takes two bytes
                base.kind     = k_push_const;
                base.stack_wb = 1'b1;
                arg_count     = opcode[0] ? 2'd2 : 2'd1;
            end
            OP_ILOAD: begin
                base.kind     = k_load;
                base.stack_wb = 1'b1;
                arg_count     = 2'd1;
            end
            OP_ILOAD_0, OP_ILOAD_1, OP_ILOAD_2, OP_ILOAD_3: begin
                base.kind      = k_load;
                base.stack_wb  = 1'b1;
                base.local_idx = opcode[LOCAL_W-1:0] - LOCAL_W'(2);
            end
            OP_ISTORE: begin
                base.kind       = k_store;
                base.stack_args = 2'd1;
                arg_count       = 2'd1;
            end
            OP_ISTORE_0, OP_ISTORE_1, OP_ISTORE_2, OP_ISTORE_3: begin
                base.kind       = k_store;
                base.stack_args = 2'd1;
                base.local_idx  = opcode[LOCAL_W-1:0] - LOCAL_W'(3);
            end
            OP_POP: begin
                base.kind       = k_pop;
                base.stack_args = 2'd1;
            end
            OP_DUP: begin
                // top is read in place, one copy pushed
                base.kind     = k_dup;
                base.stack_wb = 1'b1;
            end
            OP_IADD, OP_ISUB, OP_IMUL, OP_IDIV, OP_IREM, OP_INEG: begin
                base.kind       = k_alu;
                base.alu_op     = alu_op_e'({opcode[7], opcode[4], opcode[3], opcode[2]});
                base.stack_args = (opcode == OP_INEG) ? 2'd1 : 2'd2;
                base.stack_wb   = 1'b1;
            end
            OP_ISHL, OP_ISHR, OP_IAND: begin
                base.kind       = k_alu;
                base.alu_op     = alu_op_e'({~opcode[7], opcode[4], opcode[2], opcode[1]});
                base.stack_args = 2'd2;
                base.stack_wb   = 1'b1;
            end
            OP_IOR, OP_IXOR: begin
                base.kind       = k_alu;
                base.alu_op     = alu_op_e'({opcode[7], opcode[4], opcode[2], opcode[1]});
                base.stack_args = 2'd2;
                base.stack_wb   = 1'b1;
            end
            OP_IINC: begin
                base.kind = k_iinc;
                arg_count = 2'd2;
            end
            OP_IRETURN: begin
                base.kind       = k_ireturn;
                base.stack_args = 2'd1;
            end
            OP_RETURN: begin
                base.kind = k_return;
            end
            default: begin
                base.kind = k_illegal;
            end
        endcase
    end

endmodule

// ==== design/instr_assembler.sv ====
`timescale 1ns/100ps

module instr_assembler
    import jvm_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    credit_link.receiver bytes_in,
    credit_link.sender   instr_out
);

    logic [7:0]            rx_mem [LINK_DEPTH];
    logic [LINK_PTR_W-1:0] rx_wr, rx_rd;
    logic [LINK_CNT_W-1:0] rx_cnt;
    logic [7:0]            head;
    logic                  take;
    logic                  stall;
    logic                  emit;
    logic [1:0]            dec_args;
    decoded_instr_t        dec_base;
    logic                  collecting;
    logic [1:0]            need_q;
    logic [7:0]            op_q;
    logic [7:0]            arg_hi_q;
    decoded_instr_t        base_q;
    logic                  done;
    decoded_instr_t        done_instr;
    logic                  pend_q;
    decoded_instr_t        pend_instr;
    logic [LINK_CNT_W-1:0] icred;

    // argument bytes arrive most significant first
    function automatic decoded_instr_t finish(logic [7:0] op, decoded_instr_t b,
                                              logic [15:0] args);
        decoded_instr_t r;
        r = b;
        case (op)
            OP_BIPUSH: r.imm = {{24{args[7]}}, args[7:0]};
            OP_SIPUSH: r.imm = {{16{args[15]}}, args};
            OP_ILOAD, OP_ISTORE: r.local_idx = args[LOCAL_W-1:0];
            OP_IINC: begin
                r.local_idx = args[8 +: LOCAL_W];
                r.imm       = {{24{args[7]}}, args[7:0]};
            end
            default: r = b;
        endcase
        return r;
    endfunction

    bytecode_decoder u_decoder (
        .opcode    (head),
        .arg_count (dec_args),
        .base      (dec_base)
    );

    assign head  = rx_mem[rx_rd];
    // a finished instruction with no credit blocks further bytes
    assign stall = pend_q && (icred == '0);
    assign emit  = pend_q && (icred != '0);
    assign take  = (rx_cnt != '0) && !stall;
    assign done  = take && (collecting ? (need_q == 2'd1) : (dec_args == 2'd0));
    assign done_instr = collecting ? finish(op_q, base_q, {arg_hi_q, head}) : dec_base;

    assign bytes_in.credit = take;
    assign instr_out.valid = emit;
    assign instr_out.data  = pend_instr;

    always_ff @(posedge clk) begin
        if (bytes_in.valid) begin
            rx_mem[rx_wr] <= bytes_in.data;
        end
        if (take && !collecting) begin
            op_q   <= head;
            base_q <= dec_base;
        end
        if (take && collecting) begin
            arg_hi_q <= head;
        end
        if (done) begin
            pend_instr <= done_instr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_wr      <= '0;
            rx_rd      <= '0;
            rx_cnt     <= '0;
            collecting <= 1'b0;
            need_q     <= 2'd0;
            pend_q     <= 1'b0;
            icred      <= LINK_CNT_W'(LINK_DEPTH);
        end else begin
            if (bytes_in.valid) begin
                rx_wr <= rx_wr + LINK_PTR_W'(1);
            end
            if (take) begin
                rx_rd <= rx_rd + LINK_PTR_W'(1);
                if (!collecting) begin
                    need_q     <= dec_args;
                    collecting <= (dec_args != 2'd0);
                end else begin
                    need_q     <= need_q - 2'd1;
                    collecting <= (need_q != 2'd1);
                end
            end
            rx_cnt <= rx_cnt + LINK_CNT_W'(bytes_in.valid) - LINK_CNT_W'(take);
            pend_q <= done || (pend_q && !emit);
            icred  <= icred - LINK_CNT_W'(emit) + LINK_CNT_W'(instr_out.credit);
        end
    end

endmodule

// ==== design/stack_exec.sv ====
`timescale 1ns/100ps

module stack_exec
    import jvm_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    credit_link.receiver instr_in,
    input  logic         res_credit,
    output logic         res_valid,
    output logic [31:0]  res_value,
    output logic         illegal_seen
);

    decoded_instr_t        iq [LINK_DEPTH];
    logic [LINK_PTR_W-1:0] iq_wr, iq_rd;
    logic [LINK_CNT_W-1:0] iq_cnt;
    decoded_instr_t        cur;
    logic                  go;
    logic                  ret_go;
    logic [31:0]           stk [STACK_DEPTH];
    logic [SP_W-1:0]       sp;
    logic [STK_IDX_W-1:0]  wr_idx;
    logic [31:0]           locals [NUM_LOCALS];
    logic [LINK_CNT_W-1:0] rcred;
    logic [31:0]           top;
    logic [31:0]           nxt;
    logic [31:0]           alu_res;
    logic [31:0]           wb_val;

    // java int semantics, r is the top of stack
    function automatic logic [31:0] alu(alu_op_e op, logic [31:0] l, logic [31:0] r);
        logic signed [31:0] a;
        logic signed [31:0] b;
        logic [31:0]        y;
        a = l;
        b = r;
        case (op)
            alu_add: y = a + b;
            alu_sub: y = a - b;
            alu_mul: y = a * b;
            // min / -1 wraps back to min as in java
            alu_div: y = (b == 0) ? 32'sd0 : (b == -1) ? -a : a / b;
            alu_rem: y = (b == 0 || b == -1) ? 32'sd0 : a % b;
            alu_neg: y = -b;
            alu_or:  y = a | b;
            alu_xor: y = a ^ b;
            alu_shl: y = a << b[4:0];
            alu_shr: y = a >>> b[4:0];
            alu_and: y = a & b;
            default: y = '0;
        endcase
        return y;
    endfunction

    assign cur     = iq[iq_rd];
    // ireturn waits here until the sink has room
    assign go      = (iq_cnt != '0) && !((cur.kind == k_ireturn) && (rcred == '0));
    assign ret_go  = go && (cur.kind == k_ireturn);
    assign top     = stk[STK_IDX_W'(sp - SP_W'(1))];
    assign nxt     = stk[STK_IDX_W'(sp - SP_W'(2))];
    assign alu_res = alu(cur.alu_op, nxt, top);
    // result lands where the lowest consumed operand was
    assign wr_idx  = STK_IDX_W'(sp - SP_W'(cur.stack_args));

    assign instr_in.credit = go;

    always_comb begin
        case (cur.kind)
            k_push_const: wb_val = cur.imm;
            k_load:       wb_val = locals[cur.local_idx];
            k_dup:        wb_val = top;
            default:      wb_val = alu_res;
        endcase
    end

    always_ff @(posedge clk) begin
        if (instr_in.valid) begin
            iq[iq_wr] <= instr_in.data;
        end
        if (go && cur.stack_wb) begin
            stk[wr_idx] <= wb_val;
        end
        if (ret_go) begin
            res_value <= top;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            iq_wr        <= '0;
            iq_rd        <= '0;
            iq_cnt       <= '0;
            sp           <= '0;
            rcred        <= LINK_CNT_W'(LINK_DEPTH);
            res_valid    <= 1'b0;
            illegal_seen <= 1'b0;
            for (int i = 0; i < NUM_LOCALS; i++) begin
                locals[i] <= '0;
            end
        end else begin
            if (instr_in.valid) begin
                iq_wr <= iq_wr + LINK_PTR_W'(1);
            end
            iq_cnt    <= iq_cnt + LINK_CNT_W'(instr_in.valid) - LINK_CNT_W'(go);
            rcred     <= rcred - LINK_CNT_W'(ret_go) + LINK_CNT_W'(res_credit);
            res_valid <= ret_go;
            if (go) begin
                iq_rd <= iq_rd + LINK_PTR_W'(1);
                if (cur.kind == k_ireturn || cur.kind == k_return) begin
                    sp <= '0;
                end else begin
                    sp <= sp - SP_W'(cur.stack_args) + SP_W'(cur.stack_wb);
                end
                case (cur.kind)
                    k_store:   locals[cur.local_idx] <= top;
                    k_iinc:    locals[cur.local_idx] <= locals[cur.local_idx] + cur.imm;
                    k_illegal: illegal_seen <= 1'b1;
                    default:   ;
                endcase
            end
        end
    end

endmodule

// ==== design/jvm_core.sv ====
`timescale 1ns/100ps

module jvm_core
    import jvm_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  logic [7:0]  in_byte,
    output logic        in_credit,
    input  logic        res_credit,
    output logic        res_valid,
    output logic [31:0] res_value,
    output logic        illegal_seen
);

    // top level stream enters as plain ports
    credit_link #(.payload_t(logic [7:0]))     in_link ();
    credit_link #(.payload_t(logic [7:0]))     byte_link ();
    credit_link #(.payload_t(decoded_instr_t)) instr_link ();
    credit_link #(.payload_t(decoded_instr_t)) exec_link ();

    assign in_link.valid = in_valid;
    assign in_link.data  = in_byte;
    assign in_credit     = in_link.credit;

    credit_fifo #(.payload_t(logic [7:0])) u_byte_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .up    (in_link),
        .down  (byte_link)
    );

    instr_assembler u_assembler (
        .clk       (clk),
        .rst_n     (rst_n),
        .bytes_in  (byte_link),
        .instr_out (instr_link)
    );

    credit_fifo #(.payload_t(decoded_instr_t)) u_instr_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .up    (instr_link),
        .down  (exec_link)
    );

    stack_exec u_exec (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_in     (exec_link),
        .res_credit   (res_credit),
        .res_valid    (res_valid),
        .res_value    (res_value),
        .illegal_seen (illegal_seen)
    );

endmodule

// ==== sim/jvm_core_tb.sv ====
`timescale 1ns/100ps

module jvm_core_tb
    import jvm_pkg::*;
();

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    logic        in_valid = 1'b0;
    logic [7:0]  in_byte = 8'h00;
    logic        in_credit;
    logic        res_credit = 1'b0;
    logic        res_valid;
    logic [31:0] res_value;
    logic        illegal_seen;

    // stimulus and expectations from the vector file
    logic [7:0]  byte_q [$];
    logic [31:0] exp_q [$];
    int          illegal_from = -1;
    int          num_items = 0;
    int          bad_records = 0;
    int          fd;

    int          byte_idx = 0;
    int          src_credits = 0;
    int          rx_count = 0;
    int          credit_due [$];
    int          credits_sent = 0;
    int          last_due = 0;
    int          errors = 0;
    int          cycles = 0;
    int          limit = 1000000;
    logic        timed_out = 1'b0;
    integer      seed = 32'h81d;

    always #5 clk = ~clk;

    jvm_core dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_byte      (in_byte),
        .in_credit    (in_credit),
        .res_credit   (res_credit),
        .res_valid    (res_valid),
        .res_value    (res_value),
        .illegal_seen (illegal_seen)
    );

    // records are a tag, a count and that many hex values
    task automatic load_vectors();
        string       tag;
        string       tok;
        logic [31:0] val;
        int          n;
        int          c;
        int          rc;
        forever begin
            rc = $fscanf(fd, "%s", tag);
            if (rc != 1) begin
                break;
            end
            if (tag == "#") begin
                c = $fgetc(fd);
                while (c != 10 && c != -1) begin
                    c = $fgetc(fd);
                end
            end else if (tag == "b" || tag == "e") begin
                rc = $fscanf(fd, "%d", n);
                if (rc != 1) begin
                    $display("vector record %s has no value count", tag);
                    bad_records++;
                    break;
                end
                for (int i = 0; i < n; i++) begin
                    rc = $fscanf(fd, "%s", tok);
                    if (tag == "e" && tok == "illegal") begin
                        illegal_from = exp_q.size();
                    end else begin
                        rc = $sscanf(tok, "%h", val);
                        if (tag == "b") begin
                            byte_q.push_back(val[7:0]);
                        end else begin
                            exp_q.push_back(val);
                        end
                    end
                    num_items++;
                end
            end else begin
                $display("vector file holds an unknown record tag %s", tag);
                bad_records++;
            end
        end
    endtask

    // compare one result and schedule the credit for it
    task automatic check_result();
        logic [31:0] want;
        logic        want_ill;
        int          due;
        want_ill = (illegal_from >= 0) && (rx_count >= illegal_from);
        if (exp_q.size() == 0) begin
            $display("result %h at %0t came after all expected values were used",
                     res_value, $time);
            errors++;
        end else begin
            want = exp_q.pop_front();
            if (res_value !== want) begin
                $display("ERROR t=%0t res_value expected %h got %h", $time, want, res_value);
                errors++;
            end
        end
        if (illegal_seen !== want_ill) begin
            $display("ERROR t=%0t illegal_seen expected %b got %b", $time, want_ill,
                     illegal_seen);
            errors++;
        end
        rx_count++;
        // at most LINK_DEPTH results may wait for the sink
        if (rx_count - credits_sent > LINK_DEPTH) begin
            $display("result at %0t was sent while the sink had no free slot", $time);
            errors++;
        end
        // sink works through results in order, 0 to 5 cycles on each
        due = cycles;
        if (due <= last_due) begin
            due = last_due + 1;
        end
        due = due + int'($unsigned($random(seed)) % 32'd6);
        last_due = due;
        credit_due.push_back(due);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= limit) begin
            timed_out = 1'b1;
        end
        if (!rst_n) begin
            in_valid    <= 1'b0;
            res_credit  <= 1'b0;
            src_credits = LINK_DEPTH;
        end else begin
            // each in_credit pulse frees one slot in the byte FIFO
            if (in_credit) begin
                src_credits++;
            end
            if (byte_idx < byte_q.size() && src_credits > 0) begin
                in_valid <= 1'b1;
                in_byte  <= byte_q[byte_idx];
                byte_idx++;
                src_credits--;
            end else begin
                in_valid <= 1'b0;
            end
            if (res_valid) begin
                check_result();
            end
            if (credit_due.size() > 0 && cycles >= credit_due[0]) begin
                res_credit <= 1'b1;
                credits_sent++;
                void'(credit_due.pop_front());
            end else begin
                res_credit <= 1'b0;
            end
        end
    end

    initial begin
        fd = $fopen("sim/jvm_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/jvm_vectors.txt, nothing to run");
            $display(">>> FAIL");
            $finish;
        end else begin
            load_vectors();
            $fclose(fd);
            limit = 40 * num_items + 200;
            repeat (2) begin
                @(posedge clk);
            end
            rst_n <= 1'b1;
            while (!timed_out && !(byte_idx == byte_q.size() && exp_q.size() == 0)) begin
                @(posedge clk);
            end
            // a few more cycles to catch stray results
            repeat (20) begin
                @(posedge clk);
            end
            if (timed_out) begin
                $display("timeout after %0d cycles with %0d of %0d bytes sent",
                         cycles, byte_idx, byte_q.size());
            end
            $display("errors %0d, bad vector records %0d, unreceived results %0d",
                     errors, bad_records, exp_q.size());
            if (errors == 0 && bad_records == 0 && exp_q.size() == 0 && !timed_out) begin
                $display(">>> PASS");
            end else begin
                $display(">>> FAIL");
            end
            $finish;
        end
    end

endmodule

// ==== sim/jvm_vectors.txt ====
# b n hh ...  n bytecode bytes in hex, sent in order
# e n vv ...  n expected ireturn results in hex, illegal = flag set from the next result on
# constants, nop and immediates
b 18 02 ac 03 ac 04 ac 05 ac 06 ac 07 ac 08 ac 00 10 85 ac
e 8 ffffffff 00000000 00000001 00000002 00000003 00000004 00000005 ffffff85
b 14 10 80 ac 10 7f ac 11 80 01 ac 11 12 34 ac
e 4 ffffff80 0000007f ffff8001 00001234
# iadd, wrap, isub
b 18 10 64 10 e2 60 ac 04 10 1f 78 02 60 ac 06 10 0a 64 ac
e 3 00000046 7fffffff fffffff9
# imul with negative operand, dup and wrap
b 16 11 7f ff 11 c0 00 68 ac 11 7f ff 59 68 59 68 ac
e 2 e0004000 7ffe0001
# idiv signs, divide by zero, min by -1
b 17 10 f9 05 6c ac 10 07 10 fe 6c ac 10 f9 10 fe 6c ac
e 3 fffffffd fffffffd 00000003
b 11 08 03 6c ac 04 10 1f 78 02 6c ac
e 2 00000000 80000000
# irem signs and remainder by zero
b 15 10 f9 05 70 ac 10 07 10 fe 70 ac 08 03 70 ac
e 3 ffffffff 00000001 00000000
# ineg, shifts with counts above 31, logic ops
b 13 08 74 ac 06 10 21 78 ac 10 80 05 7a ac
e 3 fffffffb 00000006 ffffffe0
b 23 10 80 10 24 7a ac 10 5c 10 f0 7e ac 10 0c 10 30 80 ac 10 0f 02 82 ac
e 4 fffffff8 00000050 0000003c fffffff0
# locals persist across programs, then pop and dup
b 13 08 3b 10 09 3c 11 01 00 36 02 02 3e b1
b 17 1a 1b 60 ac 15 02 ac 84 03 fb 15 03 ac 1d 1c 64 ac
e 4 0000000e 00000100 fffffffa fffffefa
b 14 84 00 64 15 00 ac 04 05 57 ac 1b 59 68 ac
e 3 00000069 00000001 00000051
# back to back returns against slow result credits
b 30 10 21 ac 10 22 ac 10 23 ac 10 24 ac 10 25 ac 10 26 ac 10 27 ac 10 28 ac 10 29 ac 10 2a ac
e 10 00000021 00000022 00000023 00000024 00000025 00000026 00000027 00000028 00000029 0000002a
# unsupported opcode, then normal programs
b 1 a7
e 1 illegal
b 6 1a ac 08 08 68 ac
e 2 00000069 00000019

// ==== jvm_core.f ====
design/jvm_pkg.sv
design/credit_link.sv
design/credit_fifo.sv
design/bytecode_decoder.sv
design/instr_assembler.sv
design/stack_exec.sv
design/jvm_core.sv
sim/jvm_core_tb.sv

// ==== Makefile ====
TOP = jvm_core_tb

all: run

build:
	verilator --binary -j 0 --top-module $(TOP) -f jvm_core.f -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q '^>>> PASS$$' sim.log

lint:
	verilator --lint-only -Wall --timing --top-module jvm_core -f jvm_core.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
